// File: Bender.yml
package:
  name: periph_cluster

sources:
  - common/periph_pkg.sv
  - src/periph_apb_ctrl.sv
  - gpio/periph_gpio.sv
  - timer/periph_timer.sv
  - src/periph_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_periph_top.sv

// File: common/periph_pkg.sv
/*
 * Peripheral cluster package.
 * Bus and pin widths, APB address map, per-block register offsets,
 * controller states and timer control bit positions.
 */

package periph_pkg;

    // bus and pin widths
    localparam int DATA_W = 32;   // APB data and register width
    localparam int ADDR_W = 12;   // APB byte address
    localparam int GPIO_W = 8;    // number of GPIO pins
    localparam int OFFS_W = 4;    // register offset inside one slot

    // each slot spans 256 bytes, the slot index sits above this bit
    localparam int SLOT_SHIFT = 8;

    // slot base addresses, 0x200 and up is unmapped
    localparam logic [ADDR_W-1:0] SLOT_GPIO  = 12'h000;
    localparam logic [ADDR_W-1:0] SLOT_TIMER = 12'h100;

    // decoded access target
    typedef enum logic [1:0]
    {
        SLOT_NONE_E  = 2'd0,  // unmapped, answered with pslverr
        SLOT_GPIO_E  = 2'd1,
        SLOT_TIMER_E = 2'd2
    } periph_slot_e;

    // GPIO register offsets
    typedef enum logic [OFFS_W-1:0]
    {
        GPIO_GPI = 4'h0,      // synchronized pin inputs, read only
        GPIO_GPO = 4'h4,      // output values
        GPIO_DIR = 4'h8       // direction, exported only
    } gpio_reg_e;

    // timer register offsets
    typedef enum logic [OFFS_W-1:0]
    {
        TMR_CTRL = 4'h0,      // enable and auto-reload
        TMR_CMP  = 4'h4,      // compare value
        TMR_CNT  = 4'h8,      // free counter, writable
        TMR_STAT = 4'hC       // sticky match flag, w1c
    } timer_reg_e;

    // APB phase tracking
    typedef enum logic [1:0]
    {
        APB_IDLE   = 2'd0,
        APB_SETUP  = 2'd1,
        APB_ACCESS = 2'd2
    } apb_state_e;

    // timer control bits
    localparam int TMR_CTRL_EN     = 0;  // count enable
    localparam int TMR_CTRL_RELOAD = 1;  // wrap to zero on match

endpackage : periph_pkg

// File: compile.f
common/periph_pkg.sv
src/periph_apb_ctrl.sv
gpio/periph_gpio.sv
timer/periph_timer.sv
src/periph_top.sv
verification/tb_clk_gen.sv
verification/tb_periph_top.sv

// File: gpio/periph_gpio.sv
/*
 * GPIO register block.
 * Two-flop input synchronizer feeding GPI, plus GPO and DIR registers
 * written from the low pin bits of the bus data.
 */

`timescale 1ns/1ps

module periph_gpio
(
    input  logic                          clk,
    input  logic                          resetn,
    // controller side
    input  logic [periph_pkg::OFFS_W-1:0] reg_offs_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    input  logic                          we_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    // pin side
    input  logic [periph_pkg::GPIO_W-1:0] gpi_i,
    output logic [periph_pkg::GPIO_W-1:0] gpo_o,
    output logic [periph_pkg::GPIO_W-1:0] gpd_o
);
    import periph_pkg::*;

    logic [GPIO_W-1:0] gpi_meta;  // first sync stage
    logic [GPIO_W-1:0] gpi_sync;  // value seen by GPI
    logic [GPIO_W-1:0] gpo_r;
    logic [GPIO_W-1:0] dir_r;
    logic              gpo_we;
    logic              dir_we;

    // GPI has no strobe, writes there fall through
    assign gpo_we = we_i && (reg_offs_i == GPIO_GPO);
    assign dir_we = we_i && (reg_offs_i == GPIO_DIR);

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            gpi_meta <= '0;
            gpi_sync <= '0;
        end
        else
        begin
            gpi_meta <= gpi_i;     // async pins land here
            gpi_sync <= gpi_meta;
        end
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            gpo_r <= '0;
            dir_r <= '0;
        end
        else
        begin
            if (gpo_we)
                gpo_r <= wdata_i[GPIO_W-1:0];
            if (dir_we)
                dir_r <= wdata_i[GPIO_W-1:0];
        end
    end

    // zero-extended read back, unknown offsets give zero
    always_comb
    begin
        case (reg_offs_i)
            GPIO_GPI : rdata_o = {{(DATA_W-GPIO_W){1'b0}}, gpi_sync};
            GPIO_GPO : rdata_o = {{(DATA_W-GPIO_W){1'b0}}, gpo_r};
            GPIO_DIR : rdata_o = {{(DATA_W-GPIO_W){1'b0}}, dir_r};
            default  : rdata_o = '0;
        endcase
    end

    assign gpo_o = gpo_r;
    assign gpd_o = dir_r;  // no pad here, direction just leaves the block

endmodule : periph_gpio

// File: src/periph_apb_ctrl.sv
/*
 * APB slave controller for the peripheral cluster.
 * Tracks setup/access phases, decodes the slot, raises one write
 * strobe per valid write and muxes read data with error response.
 */

`timescale 1ns/1ps

module periph_apb_ctrl
(
    // clock and reset
    input  logic                          clk,
    input  logic                          resetn,
    // APB slave side
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
    input  logic [periph_pkg::DATA_W-1:0] pwdata_i,
    output logic [periph_pkg::DATA_W-1:0] prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    // peripheral side
    input  logic [periph_pkg::DATA_W-1:0] gpio_rdata_i,
    input  logic [periph_pkg::DATA_W-1:0] timer_rdata_i,
    output logic [periph_pkg::OFFS_W-1:0] reg_offs_o,
    output logic [periph_pkg::DATA_W-1:0] wdata_o,
    output logic                          gpio_we_o,
    output logic                          timer_we_o
);
    import periph_pkg::*;

    apb_state_e   state;      // current bus phase
    apb_state_e   state_nxt;
    periph_slot_e slot;       // decoded target
    logic         access;     // psel and penable both high
    logic         seq_err;    // access without a setup cycle before it
    logic         map_err;    // no block behind this address
    logic         err;
    logic         wr_ok;      // write allowed to reach a register

    assign access  = psel_i && penable_i;
    assign seq_err = access && (state != APB_SETUP);
    assign map_err = access && (slot == SLOT_NONE_E);
    assign err     = seq_err || map_err;
    assign wr_ok   = access && pwrite_i && !err;

    // phase follows the bus pins, ACCESS only lasts one cycle
    always_comb
    begin
        state_nxt = APB_IDLE;
        if (psel_i && !penable_i)
            state_nxt = APB_SETUP;
        else if (access)
            state_nxt = APB_ACCESS;  // back-to-back enable is flagged next time
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            state <= APB_IDLE;
        else
            state <= state_nxt;
    end

    // slot decode on the upper address bits
    always_comb
    begin
        if (paddr_i[ADDR_W-1:SLOT_SHIFT] == SLOT_GPIO[ADDR_W-1:SLOT_SHIFT])
            slot = SLOT_GPIO_E;
        else if (paddr_i[ADDR_W-1:SLOT_SHIFT] == SLOT_TIMER[ADDR_W-1:SLOT_SHIFT])
            slot = SLOT_TIMER_E;
        else
            slot = SLOT_NONE_E;
    end

    assign reg_offs_o = paddr_i[OFFS_W-1:0];  // peripherals decode this themselves
    assign wdata_o    = pwdata_i;
    assign gpio_we_o  = wr_ok && (slot == SLOT_GPIO_E);
    assign timer_we_o = wr_ok && (slot == SLOT_TIMER_E);

    // no wait states, error only during access
    assign pready_o  = access;
    assign pslverr_o = err;

    // read mux, errored or idle reads give zero
    always_comb
    begin
        prdata_o = '0;
        if (access && !pwrite_i && !err)
        begin
            case (slot)
                SLOT_GPIO_E  : prdata_o = gpio_rdata_i;
                SLOT_TIMER_E : prdata_o = timer_rdata_i;
                default      : prdata_o = '0;
            endcase
        end
    end

endmodule : periph_apb_ctrl

// File: src/periph_top.sv
/*
 * Peripheral cluster top level.
 * APB controller in front of the GPIO block and the compare timer.
 */

`timescale 1ns/1ps

module periph_top
(
    input  logic                          clk,
    input  logic                          resetn,
    // APB slave
    input  logic                          psel_i,
    input  logic                          penable_i,
    input  logic                          pwrite_i,
    input  logic [periph_pkg::ADDR_W-1:0] paddr_i,
    input  logic [periph_pkg::DATA_W-1:0] pwdata_i,
    output logic [periph_pkg::DATA_W-1:0] prdata_o,
    output logic                          pready_o,
    output logic                          pslverr_o,
    // GPIO pins
    input  logic [periph_pkg::GPIO_W-1:0] gpi_i,
    output logic [periph_pkg::GPIO_W-1:0] gpo_o,
    output logic [periph_pkg::GPIO_W-1:0] gpd_o,
    // timer interrupt
    output logic                          irq_o
);
    import periph_pkg::*;

    logic [OFFS_W-1:0] reg_offs;     // shared offset to both blocks
    logic [DATA_W-1:0] wdata;
    logic              gpio_we;
    logic              timer_we;
    logic [DATA_W-1:0] gpio_rdata;
    logic [DATA_W-1:0] timer_rdata;

    periph_apb_ctrl periph_apb_ctrl_i
    (
        .clk           ( clk         ),
        .resetn        ( resetn      ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .gpio_rdata_i  ( gpio_rdata  ),
        .timer_rdata_i ( timer_rdata ),
        .reg_offs_o    ( reg_offs    ),
        .wdata_o       ( wdata       ),
        .gpio_we_o     ( gpio_we     ),
        .timer_we_o    ( timer_we    )
    );

    periph_gpio periph_gpio_i
    (
        .clk        ( clk        ),
        .resetn     ( resetn     ),
        .reg_offs_i ( reg_offs   ),
        .wdata_i    ( wdata      ),
        .we_i       ( gpio_we    ),
        .rdata_o    ( gpio_rdata ),
        .gpi_i      ( gpi_i      ),
        .gpo_o      ( gpo_o      ),
        .gpd_o      ( gpd_o      )
    );

    periph_timer periph_timer_i
    (
        .clk        ( clk         ),
        .resetn     ( resetn      ),
        .reg_offs_i ( reg_offs    ),
        .wdata_i    ( wdata       ),
        .we_i       ( timer_we    ),
        .rdata_o    ( timer_rdata ),
        .irq_o      ( irq_o       )
    );

endmodule : periph_top

// File: timer/periph_timer.sv
/*
 * Compare timer.
 * Counter runs while enabled, sets a sticky match flag on compare and
 * then wraps to zero or stops. Flag drives the interrupt line.
 */

`timescale 1ns/1ps

module periph_timer
(
    input  logic                          clk,
    input  logic                          resetn,
    // controller side
    input  logic [periph_pkg::OFFS_W-1:0] reg_offs_i,
    input  logic [periph_pkg::DATA_W-1:0] wdata_i,
    input  logic                          we_i,
    output logic [periph_pkg::DATA_W-1:0] rdata_o,
    // interrupt
    output logic                          irq_o
);
    import periph_pkg::*;

    logic              ctrl_en;      // CTRL bit 0
    logic              ctrl_reload;  // CTRL bit 1
    logic [DATA_W-1:0] cmp_r;
    logic [DATA_W-1:0] cnt_r;
    logic              match_flag;   // STAT bit 0, sticky
    logic              match;        // compare hit this cycle
    logic              ctrl_we;
    logic              cmp_we;
    logic              cnt_we;
    logic              stat_clr;

    assign ctrl_we  = we_i && (reg_offs_i == TMR_CTRL);
    assign cmp_we   = we_i && (reg_offs_i == TMR_CMP);
    assign cnt_we   = we_i && (reg_offs_i == TMR_CNT);
    assign stat_clr = we_i && (reg_offs_i == TMR_STAT) && wdata_i[0];  // w1c

    assign match = ctrl_en && (cnt_r == cmp_r);

    // control, a bus write beats the one-shot auto clear
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
        begin
            ctrl_en     <= 1'b0;
            ctrl_reload <= 1'b0;
        end
        else if (ctrl_we)
        begin
            ctrl_en     <= wdata_i[TMR_CTRL_EN];
            ctrl_reload <= wdata_i[TMR_CTRL_RELOAD];
        end
        else if (match && !ctrl_reload)
            ctrl_en <= 1'b0;  // one-shot done
    end

    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            cmp_r <= '0;
        else if (cmp_we)
            cmp_r <= wdata_i;
    end

    // counter: load, wrap, hold or count
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            cnt_r <= '0;
        else if (cnt_we)
            cnt_r <= wdata_i;
        else if (match)
        begin
            if (ctrl_reload)
                cnt_r <= '0;
            // one-shot keeps the compare value
        end
        else if (ctrl_en)
            cnt_r <= cnt_r + 1'b1;
    end

    // sticky flag, a new hit wins over a same-cycle clear
    always_ff @(posedge clk, negedge resetn)
    begin
        if (!resetn)
            match_flag <= 1'b0;
        else if (match)
            match_flag <= 1'b1;
        else if (stat_clr)
            match_flag <= 1'b0;
    end

    assign irq_o = match_flag;  // level irq, high until cleared

    always_comb
    begin
        rdata_o = '0;
        case (reg_offs_i)
            TMR_CTRL :
            begin
                rdata_o[TMR_CTRL_EN]     = ctrl_en;
                rdata_o[TMR_CTRL_RELOAD] = ctrl_reload;
            end
            TMR_CMP  : rdata_o = cmp_r;
            TMR_CNT  : rdata_o = cnt_r;
            TMR_STAT : rdata_o[0] = match_flag;
            default  : rdata_o = '0;
        endcase
    end

endmodule : periph_timer

// File: verification/tb_clk_gen.sv
/*
 * Testbench clock and reset source.
 * 8 ns clock, active-low reset held for the first 10 rising edges.
 */

`timescale 1ns/1ps

module tb_clk_gen
(
    output logic clk,
    output logic resetn
);
    localparam int HALF_PERIOD  = 4;   // ns
    localparam int RESET_CYCLES = 10;

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;  // release on an edge, like a synced reset
    end

endmodule : tb_clk_gen

// File: verification/tb_periph_top.sv
/*
 * Table-driven testbench for the peripheral cluster.
 * Runs APB reads and writes from a step table and checks read data,
 * pslverr and the GPIO and irq pins after every step.
 */

`timescale 1ns/1ps

module tb_periph_top;
    import periph_pkg::*;

    localparam int MAX_STEPS      = 40;
    localparam int PREADY_TIMEOUT = 16;
    localparam int RESET_TIMEOUT  = 50;

    logic              clk;
    logic              resetn;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [ADDR_W-1:0] paddr_i;
    logic [DATA_W-1:0] pwdata_i;
    logic [DATA_W-1:0] prdata_o;
    logic              pready_o;
    logic              pslverr_o;
    logic [GPIO_W-1:0] gpi_i;
    logic [GPIO_W-1:0] gpo_o;
    logic [GPIO_W-1:0] gpd_o;
    logic              irq_o;

    // step table with one column per array
    string             step_name    [MAX_STEPS];
    logic              step_wr      [MAX_STEPS];
    logic [ADDR_W-1:0] step_addr    [MAX_STEPS];
    logic [DATA_W-1:0] step_wdata   [MAX_STEPS];
    logic [GPIO_W-1:0] step_gpi     [MAX_STEPS];
    logic [DATA_W-1:0] step_rdata   [MAX_STEPS];  // expected on reads
    logic              step_err     [MAX_STEPS];
    int                step_wait    [MAX_STEPS];  // idle cycles before setup
    logic              step_nosetup [MAX_STEPS];  // enable raised without setup
    logic [GPIO_W-1:0] step_gpo     [MAX_STEPS];  // pin state after the step
    logic [GPIO_W-1:0] step_gpd     [MAX_STEPS];
    logic              step_irq     [MAX_STEPS];
    int                n_steps;

    // reference state while the table is built
    logic [GPIO_W-1:0] m_gpi;
    logic [GPIO_W-1:0] m_gpo;
    logic [GPIO_W-1:0] m_gpd;
    logic              m_irq;
    logic              m_nosetup;

    tb_clk_gen tb_clk_gen_i
    (
        .clk    ( clk    ),
        .resetn ( resetn )
    );

    periph_top periph_top_i
    (
        .clk       ( clk       ),
        .resetn    ( resetn    ),
        .psel_i    ( psel_i    ),
        .penable_i ( penable_i ),
        .pwrite_i  ( pwrite_i  ),
        .paddr_i   ( paddr_i   ),
        .pwdata_i  ( pwdata_i  ),
        .prdata_o  ( prdata_o  ),
        .pready_o  ( pready_o  ),
        .pslverr_o ( pslverr_o ),
        .gpi_i     ( gpi_i     ),
        .gpo_o     ( gpo_o     ),
        .gpd_o     ( gpd_o     ),
        .irq_o     ( irq_o     )
    );

    function automatic logic [DATA_W-1:0] pad_pins(input logic [GPIO_W-1:0] pins);
        return {{(DATA_W-GPIO_W){1'b0}}, pins};  // registers read zero-extended
    endfunction

    task automatic add_step(input string name, input logic wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, input int wait_n,
                            input logic [DATA_W-1:0] exp_rdata, input logic exp_err);
        step_name[n_steps]    = name;
        step_wr[n_steps]      = wr;
        step_addr[n_steps]    = addr;
        step_wdata[n_steps]   = wdata;
        step_wait[n_steps]    = wait_n;
        step_rdata[n_steps]   = exp_rdata;
        step_err[n_steps]     = exp_err;
        step_nosetup[n_steps] = m_nosetup;
        step_gpi[n_steps]     = m_gpi;   // pins as the model holds them now
        step_gpo[n_steps]     = m_gpo;
        step_gpd[n_steps]     = m_gpd;
        step_irq[n_steps]     = m_irq;
        n_steps++;
    endtask

    task automatic build_table();
        logic [DATA_W-1:0] r_gpo;
        logic [DATA_W-1:0] r_dir;
        logic [DATA_W-1:0] r_junk;
        logic [GPIO_W-1:0] r_gpi_a;
        logic [GPIO_W-1:0] r_gpi_b;
        r_gpo     = $urandom();
        r_dir     = $urandom();
        r_junk    = $urandom();
        r_gpi_a   = $urandom();
        r_gpi_b   = $urandom();
        n_steps   = 0;
        m_gpi     = '0;
        m_gpo     = '0;
        m_gpd     = '0;
        m_irq     = 1'b0;
        m_nosetup = 1'b0;
        // reset values
        add_step("rst_gpi",  1'b0, 12'h000, '0, 0, '0, 1'b0);
        add_step("rst_gpo",  1'b0, 12'h004, '0, 0, '0, 1'b0);
        add_step("rst_dir",  1'b0, 12'h008, '0, 0, '0, 1'b0);
        add_step("rst_ctrl", 1'b0, 12'h100, '0, 0, '0, 1'b0);
        add_step("rst_cmp",  1'b0, 12'h104, '0, 0, '0, 1'b0);
        add_step("rst_cnt",  1'b0, 12'h108, '0, 0, '0, 1'b0);
        add_step("rst_stat", 1'b0, 12'h10C, '0, 0, '0, 1'b0);
        // only the low pin bits of GPO and DIR stick
        m_gpo = r_gpo[GPIO_W-1:0];
        add_step("gpo_write", 1'b1, 12'h004, r_gpo, 0, '0, 1'b0);
        add_step("gpo_read",  1'b0, 12'h004, '0, 1, pad_pins(m_gpo), 1'b0);
        m_gpd = r_dir[GPIO_W-1:0];
        add_step("dir_write", 1'b1, 12'h008, r_dir, 0, '0, 1'b0);
        add_step("dir_read",  1'b0, 12'h008, '0, 0, pad_pins(m_gpd), 1'b0);
        // input path needs two edges through the synchronizer
        m_gpi = r_gpi_a;
        add_step("gpi_read",     1'b0, 12'h000, '0, 3, pad_pins(m_gpi), 1'b0);
        add_step("gpi_write",    1'b1, 12'h000, r_junk, 0, '0, 1'b0);
        add_step("gpi_readonly", 1'b0, 12'h000, '0, 0, pad_pins(m_gpi), 1'b0);
        m_gpi = r_gpi_b;
        add_step("gpi_read_2",   1'b0, 12'h000, '0, 4, pad_pins(m_gpi), 1'b0);
        // one-shot run stops at CMP with enable cleared
        add_step("cmp_write",   1'b1, 12'h104, 32'd5, 0, '0, 1'b0);
        add_step("ctrl_enable", 1'b1, 12'h100, 32'h1, 0, '0, 1'b0);
        m_irq = 1'b1;
        add_step("cnt_oneshot",  1'b0, 12'h108, '0, 12, 32'd5, 1'b0);
        add_step("stat_oneshot", 1'b0, 12'h10C, '0, 0, 32'h1, 1'b0);
        add_step("ctrl_oneshot", 1'b0, 12'h100, '0, 0, 32'h0, 1'b0);
        m_irq = 1'b0;
        add_step("stat_clear",   1'b1, 12'h10C, 32'h1, 0, '0, 1'b0);
        add_step("stat_cleared", 1'b0, 12'h10C, '0, 0, 32'h0, 1'b0);
        // CNT already equals CMP so auto-reload brings the flag back
        add_step("ctrl_reload", 1'b1, 12'h100, 32'h3, 0, '0, 1'b0);
        m_irq = 1'b1;
        add_step("stat_reload", 1'b0, 12'h10C, '0, 4, 32'h1, 1'b0);
        add_step("ctrl_kept",   1'b0, 12'h100, '0, 0, 32'h3, 1'b0);
        add_step("ctrl_stop",   1'b1, 12'h100, 32'h0, 0, '0, 1'b0);  // flag stays sticky
        m_irq = 1'b0;
        add_step("stat_clear_2", 1'b1, 12'h10C, 32'h1, 0, '0, 1'b0);
        // unmapped slots must leave every register alone
        add_step("unmapped_wr",   1'b1, 12'h204, r_junk, 0, '0, 1'b1);
        add_step("unmapped_rd",   1'b0, 12'h204, '0, 0, '0, 1'b1);
        add_step("unmapped_high", 1'b0, 12'hF08, '0, 0, '0, 1'b1);
        // enable without a setup cycle is refused like an unmapped access
        m_nosetup = 1'b1;
        add_step("nosetup_wr", 1'b1, 12'h004, r_junk, 0, '0, 1'b1);
        add_step("nosetup_rd", 1'b0, 12'h004, '0, 0, '0, 1'b1);
        m_nosetup = 1'b0;
        add_step("gpo_kept",      1'b0, 12'h004, '0, 0, pad_pins(m_gpo), 1'b0);
        add_step("dir_kept",      1'b0, 12'h008, '0, 0, pad_pins(m_gpd), 1'b0);
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_gpio(input string name, input logic [GPIO_W-1:0] exp,
                              input logic [GPIO_W-1:0] act);
        if (act !== exp)
        begin
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1, "pin mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("Testbench failed");
        $fatal(1, "timeout");
    endtask

    // one APB transfer sampled on the falling edge of the access cycle
    task automatic apb_access(input int idx, output logic [DATA_W-1:0] rdata,
                              output logic err);
        int cycles;
        @(posedge clk);
        gpi_i <= step_gpi[idx];
        repeat (step_wait[idx]) @(posedge clk);
        psel_i    <= 1'b1;
        penable_i <= step_nosetup[idx];  // straight into access, no setup phase
        pwrite_i  <= step_wr[idx];
        paddr_i   <= step_addr[idx];
        pwdata_i  <= step_wdata[idx];
        if (!step_nosetup[idx])
        begin
            @(posedge clk);
            penable_i <= 1'b1;
        end
        cycles = 0;
        @(negedge clk);
        while (pready_o !== 1'b1)
        begin
            cycles++;
            if (cycles > PREADY_TIMEOUT)
                report_timeout({"pready in ", step_name[idx]});
            @(negedge clk);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk);          // write lands on this edge
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
        pwrite_i  <= 1'b0;
    endtask

    initial
    begin
        logic [DATA_W-1:0] rdata;
        logic              err;
        int                cycles;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        gpi_i     = '0;
        void'($urandom(32'hd859));
        build_table();
        cycles = 0;
        while (resetn !== 1'b1)
        begin
            @(posedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT)
                report_timeout("reset release");
        end
        @(negedge clk);
        check_err("reset pready_o", 1'b0, pready_o);   // bus idle out of reset
        check_err("reset pslverr_o", 1'b0, pslverr_o);
        for (int i = 0; i < n_steps; i++)
        begin
            apb_access(i, rdata, err);
            check_err({step_name[i], " pslverr"}, step_err[i], err);
            if (!step_wr[i])
                check_data({step_name[i], " prdata"}, step_rdata[i], rdata);
            @(negedge clk);  // registers settled after the access edge
            check_gpio({step_name[i], " gpo_o"}, step_gpo[i], gpo_o);
            check_gpio({step_name[i], " gpd_o"}, step_gpd[i], gpd_o);
            check_err({step_name[i], " irq_o"}, step_irq[i], irq_o);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule : tb_periph_top
